// File: bench/opp_tb.sv
`default_nettype none
`include "opp_macros.svh"

module opp_tb;
	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		opp_pkg::chan_t   chan;
		opp_pkg::dac_op_t op;
		opp_pkg::level_t  level;
	} exp_t;

	logic                clk_in;
	logic                reset_in;
	logic                in_valid;
	opp_pkg::chan_t      in_chan;
	opp_pkg::sample_t    in_data;
	logic                in_lock_en;
	logic                in_credit;
	logic                cfg_valid;
	opp_pkg::chan_t      cfg_chan;
	opp_pkg::opp_field_t cfg_field;
	opp_pkg::level_t     cfg_data;
	logic                update;
	logic                out_valid;
	opp_pkg::chan_t      out_chan;
	opp_pkg::dac_op_t    out_op;
	opp_pkg::level_t     out_level;
	logic                dac_credit;

	// records from the data file
	byte         rec_kind [$];
	logic [31:0] rec_a [$];
	logic [31:0] rec_b [$];
	logic [31:0] rec_c [$];
	logic [31:0] rec_d [$];
	logic [31:0] rec_e [$];
	int          n_rec = 0;

	exp_t   exp_q [`OPP_N_CHAN][$];    // per channel, in order
	int     errors    = 0;
	int     checks    = 0;
	int     sent      = 0;             // samples pushed upstream
	int     cred_back = 0;             // in_credit pulses seen
	int     dac_taken = 0;             // instructions seen
	int     dac_freed = 0;             // dac_credit pulses given
	integer seed      = 32'h33b0;

	opp_top dut0 (.*);

	initial begin
		clk_in = 1'b0;
		forever #5 clk_in = ~clk_in;
	end

	////////////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////////////

	task automatic check_level(input string name, input opp_pkg::level_t got,
		input opp_pkg::level_t exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_op(input string name, input opp_pkg::dac_op_t got,
		input opp_pkg::dac_op_t exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_chan(input string name, input opp_pkg::chan_t got,
		input opp_pkg::chan_t exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	function automatic int pending_results();
		int n;
		n = 0;
		for (int c = 0; c < `OPP_N_CHAN; c++) begin
			n += exp_q[c].size();
		end
		return n;
	endfunction

	function automatic bit head_matches(input int c, input opp_pkg::level_t level,
		input opp_pkg::dac_op_t op);
		if (exp_q[c].size() == 0) begin
			return 1'b0;
		end
		return (exp_q[c][0].level === level) && (exp_q[c][0].op === op);
	endfunction

	// queue the instruction came from
	function automatic opp_pkg::chan_t source_chan(input opp_pkg::chan_t tag,
		input opp_pkg::level_t level, input opp_pkg::dac_op_t op);
		opp_pkg::chan_t src;
		src = tag;                              // tagged channel wins
		if (!head_matches(tag, level, op)) begin
			for (int c = 0; c < `OPP_N_CHAN; c++) begin
				if (head_matches(c, level, op)) begin
					src = opp_pkg::chan_t'(c);    // mistagged result
				end
			end
		end
		return src;
	endfunction

	////////////////////////////////////////////////////////////////////
	// stimulus tasks
	////////////////////////////////////////////////////////////////////

	task automatic write_config(input logic [31:0] chan, input logic [31:0] field,
		input logic [31:0] data);
		@(posedge clk_in);
		#1;
		cfg_valid = 1'b1;
		cfg_chan  = opp_pkg::chan_t'(chan[1:0]);
		cfg_field = opp_pkg::opp_field_t'(field[1:0]);
		cfg_data  = opp_pkg::level_t'(data[15:0]);
		@(posedge clk_in);
		#1;
		cfg_valid = 1'b0;
	endtask

	task automatic wait_drained();
		while (pending_results() != 0) begin
			@(posedge clk_in);    // watchdog bounds this
		end
	endtask

	task automatic pulse_update();
		wait_drained();       // nothing in flight during commit
		@(posedge clk_in);
		#1;
		update = 1'b1;
		@(posedge clk_in);
		#1;
		update = 1'b0;
	endtask

	task automatic send_sample(input logic [31:0] chan, input logic [31:0] data,
		input logic [31:0] lock, input logic [31:0] level, input logic [31:0] op);
		exp_t e;
		@(posedge clk_in);
		while (`OPP_IN_DEPTH - sent + cred_back <= 0) begin
			@(posedge clk_in);    // out of upstream credits
		end
		#1;
		in_valid   = 1'b1;
		in_chan    = opp_pkg::chan_t'(chan[1:0]);
		in_data    = opp_pkg::sample_t'(data[17:0]);
		in_lock_en = lock[0];
		e.chan     = opp_pkg::chan_t'(chan[1:0]);
		e.op       = opp_pkg::dac_op_t'(op[0]);
		e.level    = opp_pkg::level_t'(level[15:0]);
		exp_q[e.chan].push_back(e);
		sent++;
		@(posedge clk_in);
		#1;
		in_valid = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////
	// output monitor, upstream and dac credit model
	////////////////////////////////////////////////////////////////////

	always @(negedge clk_in) begin : monitor
		exp_t           e;
		opp_pkg::chan_t src;
		if (!reset_in) begin
			if (in_credit) cred_back++;
			if (cred_back > sent) begin
				$display("in_credit returned with no sample outstanding");
				errors++;
			end
			if (out_valid) begin
				dac_taken++;
				if (dac_taken - dac_freed > `OPP_DAC_CREDITS) begin
					$display("instruction issued without a free dac queue entry");
					errors++;
				end
				src = source_chan(out_chan, out_level, out_op);
				if (exp_q[src].size() == 0) begin
					$display("instruction on channel %0d with no result expected", out_chan);
					errors++;
				end else begin
					e = exp_q[src].pop_front();
					check_chan("out_chan", out_chan, e.chan);
					check_level("out_level", out_level, e.level);
					check_op("out_op", out_op, e.op);
					checks++;
				end
			end
		end
	end

	initial begin : dac_model
		int wait_cyc;
		wait_cyc = 0;
		forever begin
			@(posedge clk_in);
			#1;
			dac_credit = 1'b0;
			if (dac_taken > dac_freed) begin
				if (wait_cyc == 0) begin
					dac_credit = 1'b1;    // one queue entry consumed
					dac_freed++;
					wait_cyc   = 1 + ($unsigned($random(seed)) % 5);
				end else begin
					wait_cyc--;
				end
			end
		end
	end

	initial begin : watchdog
		wait (n_rec != 0);
		repeat (n_rec * 200) @(posedge clk_in);
		$display("watchdog timeout after %0d cycles with %0d results missing",
			n_rec * 200, pending_results());
		$display("TESTBENCH FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////

	initial begin : main_seq
		int          fh;
		int          code;
		string       line;
		byte         kind;
		logic [31:0] col_a;
		logic [31:0] col_b;
		logic [31:0] col_c;
		logic [31:0] col_d;
		logic [31:0] col_e;
		int          test_num;
		int          err_start;
		int          n_smp;
		reset_in   = 1'b1;
		in_valid   = 1'b0;
		in_chan    = '0;
		in_data    = '0;
		in_lock_en = 1'b0;
		cfg_valid  = 1'b0;
		cfg_chan   = '0;
		cfg_field  = opp_pkg::FIELD_MAX;
		cfg_data   = '0;
		update     = 1'b0;
		dac_credit = 1'b0;
		test_num   = 0;
		err_start  = 0;
		n_smp      = 0;

		fh = $fopen("bench/opp_testdata.txt", "r");
		if (fh == 0) begin
			$display("cannot open test data file bench/opp_testdata.txt");
			errors++;
		end else begin
			while (!$feof(fh)) begin
				line = "";
				code = $fgets(line, fh);
				if (code != 0 && line.len() > 0) begin
					kind  = line.getc(0);
					col_a = '0;
					col_b = '0;
					col_c = '0;
					col_d = '0;
					col_e = '0;
					if (kind == "C" || kind == "S") begin
						code = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h",
							col_a, col_b, col_c, col_d, col_e);
					end
					if (kind == "C" || kind == "S" || kind == "U" || kind == "K") begin
						rec_kind.push_back(kind);
						rec_a.push_back(col_a);
						rec_b.push_back(col_b);
						rec_c.push_back(col_c);
						rec_d.push_back(col_d);
						rec_e.push_back(col_e);
					end
				end
			end
			$fclose(fh);
			n_rec = rec_kind.size();
		end

		repeat (8) @(posedge clk_in);
		#1;
		reset_in = 1'b0;

		for (int i = 0; i < n_rec; i++) begin
			case (rec_kind[i])
				"C": write_config(rec_a[i], rec_b[i], rec_c[i]);
				"U": pulse_update();
				"S": begin
					send_sample(rec_a[i], rec_b[i], rec_c[i], rec_d[i], rec_e[i]);
					n_smp++;
				end
				default: begin    // check line closes the test
					wait_drained();
					test_num++;
					if (errors == err_start) begin
						$display("test %0d: %0d samples ok", test_num, n_smp);
					end else begin
						$display("test %0d: %0d samples, %0d errors", test_num, n_smp,
							errors - err_start);
					end
					err_start = errors;
					n_smp     = 0;
				end
			endcase
		end

		repeat (4) @(posedge clk_in);    // catch stray instructions
		$display("%0d tests, %0d results checked, %0d errors", test_num, checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/opp_testdata.txt
# C chan field data | U | S chan data18 lock exp_level exp_op | K ends a test
# field 0 max 1 min 2 init 3 mult; op 0 set 1 hold; all values hex
# test 1: default parameters, lock on, plain accumulation
S 0 00040 1 0010 0
S 0 00080 1 0030 0
S 1 3fffc 1 ffff 0
S 1 3fff0 1 fffb 0
S 2 01000 1 0400 0
S 3 00003 1 0000 0
K
# test 2: gain 128 on channels 0 and 1, multiply and add saturation
C 0 3 0080
C 1 3 0080
U
S 0 00400 1 7fff 0
S 0 00040 1 7fff 0
S 1 3f800 1 8000 0
S 1 3fff0 1 8000 0
S 2 00010 1 0004 0
K
# test 3: bounds on channel 3, commit only on update
C 3 0 0100
C 3 1 ff00
C 3 2 0050
S 3 00800 1 0200 0
U
S 3 00400 1 0100 0
S 3 3f000 1 ff00 0
S 3 00040 1 ff10 0
K
# test 4: lock off holds the clamped init, lock on resumes from it
C 2 2 7000
C 2 0 1000
U
S 2 00000 0 1000 1
S 2 3ff00 1 0fc0 0
S 3 00000 0 0050 1
S 3 00040 1 0060 0
K
# test 5: burst over all channels, dac credits scarce
S 0 00004 1 0080 0
S 1 0000c 1 0180 0
S 2 00100 1 1000 0
S 3 00080 1 0080 0
S 0 00008 1 0180 0
S 1 3fff8 1 0080 0
S 2 3fe00 1 0f80 0
S 3 00200 1 0100 0
S 0 3fffc 1 0100 0
S 1 00000 0 0000 1
S 2 00004 1 0f81 0
S 3 3fffc 1 00ff 0
K

// File: hdl/opp_channel.sv
`default_nettype none
`include "opp_macros.svh"

module opp_channel #(
	parameter opp_pkg::chan_t CHAN_ID = '0    // config address of this channel
) (
	input  logic                clk_in,
	input  logic                reset_in,
	input  logic                cfg_valid,
	input  opp_pkg::chan_t      cfg_chan,
	input  opp_pkg::opp_field_t cfg_field,
	input  opp_pkg::level_t     cfg_data,
	input  logic                update,       // commit shadows, reload prev output
	opp_sample_if.sink          smp,
	opp_result_if.source        res
);

	localparam int MSB   = `OPP_W_OUT - 1;
	localparam int CNT_W = $clog2(`OPP_COMP_LATENCY + 1);
	localparam opp_pkg::level_t LEVEL_MAX = {1'b0, {MSB{1'b1}}};    // saturation limits
	localparam opp_pkg::level_t LEVEL_MIN = {1'b1, {MSB{1'b0}}};

	// parameter bank
	opp_pkg::level_t shadow_max;
	opp_pkg::level_t shadow_min;
	opp_pkg::level_t shadow_init;
	opp_pkg::gain_t  shadow_mult;
	opp_pkg::level_t act_max;
	opp_pkg::level_t act_min;
	opp_pkg::level_t act_init;
	opp_pkg::gain_t  act_mult;

	// datapath
	opp_pkg::level_t lock_raw;     // sample cut to output width
	logic            lock_en_q;
	opp_pkg::level_t prev_out;     // accumulator
	opp_pkg::level_t res_level;    // registered at end of compute
	logic signed [`OPP_W_OUT+8:0] mult_full;
	opp_pkg::level_t mult_pre;
	opp_pkg::level_t mult_sat;
	opp_pkg::level_t sum_pre;
	opp_pkg::level_t sum_sat;
	opp_pkg::level_t sel;
	opp_pkg::level_t clamp_hi;
	opp_pkg::level_t clamp_lo;
	logic            mult_ovf;
	logic            sum_ovf;

	// control
	opp_pkg::opp_state_t state;
	opp_pkg::opp_state_t nxt;
	logic [CNT_W-1:0]    cnt;          // intrastate counter
	logic                res_cred;     // collector slot free
	logic                send;

	////////////////////////////////////////////////////////////////////
	// front-panel parameters
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			shadow_max  <= `OPP_OMAX_INIT;
			shadow_min  <= `OPP_OMIN_INIT;
			shadow_init <= `OPP_OUT_INIT;
			shadow_mult <= `OPP_MULT_INIT;
		end else if (cfg_valid && cfg_chan == CHAN_ID) begin
			case (cfg_field)
				opp_pkg::FIELD_MAX:  shadow_max  <= cfg_data;
				opp_pkg::FIELD_MIN:  shadow_min  <= cfg_data;
				opp_pkg::FIELD_INIT: shadow_init <= cfg_data;
				opp_pkg::FIELD_MULT: shadow_mult <= cfg_data[7:0];    // gain in low byte
			endcase
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			act_max  <= `OPP_OMAX_INIT;
			act_min  <= `OPP_OMIN_INIT;
			act_init <= `OPP_OUT_INIT;
			act_mult <= `OPP_MULT_INIT;
		end else if (update) begin    // all channels commit together
			act_max  <= shadow_max;
			act_min  <= shadow_min;
			act_init <= shadow_init;
			act_mult <= shadow_mult;
		end
	end

	////////////////////////////////////////////////////////////////////
	// saturating arithmetic
	////////////////////////////////////////////////////////////////////

	assign mult_full = lock_raw * $signed({1'b0, act_mult});    // gain is unsigned
	assign mult_pre  = mult_full[MSB:0];
	assign mult_ovf  = mult_pre[MSB] != lock_raw[MSB];          // sign flipped
	assign mult_sat  = mult_ovf ? (lock_raw[MSB] ? LEVEL_MIN : LEVEL_MAX) : mult_pre;

	assign sum_pre  = mult_sat + prev_out;
	assign sum_ovf  = (mult_sat[MSB] == prev_out[MSB]) && (sum_pre[MSB] != prev_out[MSB]);
	assign sum_sat  = sum_ovf ? (prev_out[MSB] ? LEVEL_MIN : LEVEL_MAX) : sum_pre;

	assign sel      = lock_en_q ? sum_sat : act_init;           // hold value without lock
	assign clamp_hi = (sel < act_max) ? sel : act_max;
	assign clamp_lo = (clamp_hi > act_min) ? clamp_hi : act_min;

	always_ff @(posedge clk_in) begin
		if (state == opp_pkg::ST_IDLE && smp.valid) begin
			lock_raw  <= smp.data[`OPP_W_IN-1 -: `OPP_W_OUT];    // drop lsbs
			lock_en_q <= smp.lock_en;
		end
		if (state == opp_pkg::ST_COMPUTE && nxt == opp_pkg::ST_SEND) begin
			res_level <= clamp_lo;
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			prev_out <= `OPP_OUT_INIT;
		end else if (update) begin
			prev_out <= shadow_init;    // restart from the new init
		end else if (state == opp_pkg::ST_DONE) begin
			prev_out <= res_level;
		end
	end

	////////////////////////////////////////////////////////////////////
	// fsm
	////////////////////////////////////////////////////////////////////

	always_comb begin
		nxt = state;
		case (state)
			opp_pkg::ST_IDLE:    if (smp.valid) nxt = opp_pkg::ST_COMPUTE;
			opp_pkg::ST_COMPUTE: if (cnt == CNT_W'(`OPP_COMP_LATENCY - 1)) nxt = opp_pkg::ST_SEND;
			opp_pkg::ST_SEND:    if (res_cred) nxt = opp_pkg::ST_DONE;
			opp_pkg::ST_DONE:    nxt = opp_pkg::ST_IDLE;
		endcase
	end

	assign send = (state == opp_pkg::ST_SEND) && res_cred;

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			state    <= opp_pkg::ST_IDLE;
			cnt      <= '0;
			res_cred <= 1'b1;                                   // one slot per channel
		end else begin
			state    <= nxt;
			cnt      <= (state == opp_pkg::ST_COMPUTE && nxt == opp_pkg::ST_COMPUTE) ?
				cnt + 1'b1 : '0;
			res_cred <= (res_cred & ~send) | res.credit;
		end
	end

	assign res.valid  = send;
	assign res.level  = res_level;
	assign res.op     = lock_en_q ? opp_pkg::DAC_SET : opp_pkg::DAC_HOLD;
	assign smp.credit = (state == opp_pkg::ST_DONE);            // ready for next sample

endmodule

`default_nettype wire

// File: hdl/opp_collect.sv
`default_nettype none
`include "opp_macros.svh"

module opp_collect (
	input  logic              clk_in,
	input  logic              reset_in,
	opp_result_if.sink        chan [`OPP_N_CHAN],
	input  logic              dac_credit,    // queue entry consumed downstream
	output logic              out_valid,
	output opp_pkg::chan_t    out_chan,
	output opp_pkg::dac_op_t  out_op,
	output opp_pkg::level_t   out_level
);

	localparam int DCNT_W = $clog2(`OPP_DAC_CREDITS + 1);

	// one slot per channel
	logic [`OPP_N_CHAN-1:0] slot_vld;
	opp_pkg::level_t        slot_level [`OPP_N_CHAN];
	opp_pkg::dac_op_t       slot_op    [`OPP_N_CHAN];
	logic [`OPP_N_CHAN-1:0] res_vld;
	logic [`OPP_N_CHAN-1:0] cred_ret;     // slot freed, back to channel
	logic [`OPP_N_CHAN-1:0] gnt_mask;

	opp_pkg::chan_t         rr_ptr;       // first channel to look at
	opp_pkg::chan_t         gnt_idx;
	logic                   gnt_any;
	logic [DCNT_W-1:0]      dac_cnt;      // free queue entries

	for (genvar c = 0; c < `OPP_N_CHAN; c++) begin : g_slot
		assign res_vld[c]     = chan[c].valid;
		assign chan[c].credit = cred_ret[c];

		always_ff @(posedge clk_in) begin
			if (chan[c].valid) begin
				slot_level[c] <= chan[c].level;
				slot_op[c]    <= chan[c].op;
			end
		end
	end

	////////////////////////////////////////////////////////////////////
	// round-robin arbiter
	////////////////////////////////////////////////////////////////////

	always_comb begin
		opp_pkg::chan_t idx;
		gnt_any = 1'b0;
		gnt_idx = rr_ptr;
		for (int i = 0; i < `OPP_N_CHAN; i++) begin
			idx = rr_ptr + opp_pkg::chan_t'(i);    // wraps with the index width
			if (dac_cnt != '0 && !gnt_any && slot_vld[idx]) begin
				gnt_any = 1'b1;
				gnt_idx = idx;
			end
		end
	end

	assign gnt_mask = gnt_any ? (`OPP_N_CHAN'(1) << gnt_idx) : '0;

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			slot_vld  <= '0;
			cred_ret  <= '0;
			rr_ptr    <= '0;
			dac_cnt   <= DCNT_W'(`OPP_DAC_CREDITS);
			out_valid <= 1'b0;
		end else begin
			slot_vld  <= (slot_vld & ~gnt_mask) | res_vld;
			cred_ret  <= gnt_mask;
			dac_cnt   <= dac_cnt + DCNT_W'(dac_credit) - DCNT_W'(gnt_any);
			out_valid <= gnt_any;
			if (gnt_any) begin
				rr_ptr <= gnt_idx + 1'b1;    // winner goes last next time
			end
		end
	end

	// instruction register
	always_ff @(posedge clk_in) begin
		if (gnt_any) begin
			out_chan  <= gnt_idx;
			out_op    <= slot_op[gnt_idx];
			out_level <= slot_level[gnt_idx];
		end
	end

endmodule

`default_nettype wire

// File: hdl/opp_dispatch.sv
`default_nettype none
`include "opp_macros.svh"

module opp_dispatch (
	input  logic             clk_in,
	input  logic             reset_in,
	input  logic             in_valid,     // upstream push, only with a credit held
	input  opp_pkg::chan_t   in_chan,
	input  opp_pkg::sample_t in_data,
	input  logic             in_lock_en,
	output logic             in_credit,    // one pulse per entry leaving
	opp_sample_if.source     chan [`OPP_N_CHAN]
);

	localparam int PTR_W = $clog2(`OPP_IN_DEPTH);
	localparam int CNT_W = $clog2(`OPP_IN_DEPTH + 1);

	// fifo storage, payload only
	opp_pkg::chan_t   fifo_chan [`OPP_IN_DEPTH];
	opp_pkg::sample_t fifo_data [`OPP_IN_DEPTH];
	logic             fifo_lock [`OPP_IN_DEPTH];

	logic [PTR_W-1:0]       wr_ptr;
	logic [PTR_W-1:0]       rd_ptr;
	logic [CNT_W-1:0]       count;        // entries held
	opp_pkg::chan_t         head_chan;    // route of the head entry
	logic                   pop;          // head leaves this cycle
	logic [`OPP_N_CHAN-1:0] send_mask;    // one-hot of the target channel
	logic [`OPP_N_CHAN-1:0] chan_cred;    // one credit per channel
	logic [`OPP_N_CHAN-1:0] cred_ret;     // credit pulses from channels
	logic [`OPP_N_CHAN-1:0] snd_vld;      // registered per-channel valid
	opp_pkg::sample_t       snd_data;
	logic                   snd_lock;

	assign head_chan = fifo_chan[rd_ptr];
	assign pop       = (count != '0) && chan_cred[head_chan];    // head blocks the rest
	assign send_mask = pop ? (`OPP_N_CHAN'(1) << head_chan) : '0;

	always_ff @(posedge clk_in) begin
		if (in_valid) begin
			fifo_chan[wr_ptr] <= in_chan;
			fifo_data[wr_ptr] <= in_data;
			fifo_lock[wr_ptr] <= in_lock_en;
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			in_credit <= 1'b0;
		end else begin
			wr_ptr    <= wr_ptr + PTR_W'(in_valid);    // depth is a power of two
			rd_ptr    <= rd_ptr + PTR_W'(pop);
			count     <= count + CNT_W'(in_valid) - CNT_W'(pop);
			in_credit <= pop;                          // slot freed upstream
		end
	end

	////////////////////////////////////////////////////////////////////
	// routing and channel credits
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			snd_vld   <= '0;
			chan_cred <= '1;                           // every channel idle
		end else begin
			snd_vld   <= send_mask;
			chan_cred <= (chan_cred & ~send_mask) | cred_ret;
		end
	end

	always_ff @(posedge clk_in) begin
		if (pop) begin
			snd_data <= fifo_data[rd_ptr];
			snd_lock <= fifo_lock[rd_ptr];
		end
	end

	for (genvar c = 0; c < `OPP_N_CHAN; c++) begin : g_port
		assign chan[c].valid   = snd_vld[c];
		assign chan[c].data    = snd_data;                 // shared bus, valid selects
		assign chan[c].lock_en = snd_lock;
		assign cred_ret[c]     = chan[c].credit;
	end

endmodule

`default_nettype wire

// File: hdl/opp_if.sv
`default_nettype none

// dispatcher -> channel, credit flows back
interface opp_sample_if;
	logic             valid;      // one cycle per sample
	opp_pkg::sample_t data;       // raw lock error
	logic             lock_en;    // lock enable tag
	logic             credit;     // pulse from channel in ST_DONE

	modport source (
		output valid,
		output data,
		output lock_en,
		input  credit
	);

	modport sink (
		input  valid,
		input  data,
		input  lock_en,
		output credit
	);
endinterface

// channel -> collector, credit flows back
interface opp_result_if;
	logic             valid;      // one cycle per result
	opp_pkg::level_t  level;      // clamped output level
	opp_pkg::dac_op_t op;         // set or hold
	logic             credit;     // pulse when the slot issues

	modport source (
		output valid,
		output level,
		output op,
		input  credit
	);

	modport sink (
		input  valid,
		input  level,
		input  op,
		output credit
	);
endinterface

`default_nettype wire

// File: hdl/opp_macros.svh
`ifndef OPP_MACROS_SVH
`define OPP_MACROS_SVH

// datapath widths
`define OPP_W_IN          18    // tagged lock-error sample
`define OPP_W_OUT         16    // dac level
`define OPP_N_CHAN        4     // channel preprocessors
`define OPP_CHAN_W        2     // channel index bits

// timing and flow control
`define OPP_COMP_LATENCY  3     // cycles spent in compute
`define OPP_IN_DEPTH      4     // input fifo entries, upstream credits
`define OPP_DAC_CREDITS   2     // dac instruction queue slots

// front-panel values after reset
`define OPP_OMAX_INIT     {1'b0, {(`OPP_W_OUT-1){1'b1}}}    // full positive range
`define OPP_OMIN_INIT     {1'b1, {(`OPP_W_OUT-1){1'b0}}}    // full negative range
`define OPP_OUT_INIT      {`OPP_W_OUT{1'b0}}                // start from zero
`define OPP_MULT_INIT     8'd1                              // unity gain

`endif

// File: hdl/opp_pkg.sv
`default_nettype none
`include "opp_macros.svh"

package opp_pkg;

	////////////////////////////////////////////////////////////////////
	// control encodings
	////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		ST_IDLE,        // wait for a sample
		ST_COMPUTE,     // counted arithmetic latency
		ST_SEND,        // wait for slot credit, present result
		ST_DONE         // latch prev output, return sample credit
	} opp_state_t;

	typedef enum logic [1:0] {
		FIELD_MAX,      // upper clamp
		FIELD_MIN,      // lower clamp
		FIELD_INIT,     // value when lock is off
		FIELD_MULT      // gain, low 8 bits of cfg data
	} opp_field_t;

	typedef enum logic {
		DAC_SET,        // lock on, servo output
		DAC_HOLD        // lock off, init output
	} dac_op_t;

	////////////////////////////////////////////////////////////////////
	// data types
	////////////////////////////////////////////////////////////////////

	typedef logic signed [`OPP_W_IN-1:0]  sample_t;   // lock error in
	typedef logic signed [`OPP_W_OUT-1:0] level_t;    // dac level out
	typedef logic        [7:0]            gain_t;     // unsigned multiplier
	typedef logic        [`OPP_CHAN_W-1:0] chan_t;    // channel tag

endpackage

`default_nettype wire

// File: hdl/opp_top.sv
`default_nettype none
`include "opp_macros.svh"

module opp_top (
	input  logic                clk_in,
	input  logic                reset_in,
	// tagged samples in
	input  logic                in_valid,
	input  opp_pkg::chan_t      in_chan,
	input  opp_pkg::sample_t    in_data,
	input  logic                in_lock_en,
	output logic                in_credit,
	// front panel
	input  logic                cfg_valid,
	input  opp_pkg::chan_t      cfg_chan,
	input  opp_pkg::opp_field_t cfg_field,
	input  opp_pkg::level_t     cfg_data,
	input  logic                update,
	// dac instructions out
	output logic                out_valid,
	output opp_pkg::chan_t      out_chan,
	output opp_pkg::dac_op_t    out_op,
	output opp_pkg::level_t     out_level,
	input  logic                dac_credit
);

	opp_sample_if smp_if [`OPP_N_CHAN] ();    // dispatcher to channels
	opp_result_if res_if [`OPP_N_CHAN] ();    // channels to collector

	opp_dispatch dispatch0 (
		.clk_in     (clk_in),
		.reset_in   (reset_in),
		.in_valid   (in_valid),
		.in_chan    (in_chan),
		.in_data    (in_data),
		.in_lock_en (in_lock_en),
		.in_credit  (in_credit),
		.chan       (smp_if)
	);

	for (genvar g = 0; g < `OPP_N_CHAN; g++) begin : g_chan
		opp_channel #(
			.CHAN_ID (opp_pkg::chan_t'(g))
		) channel0 (
			.clk_in    (clk_in),
			.reset_in  (reset_in),
			.cfg_valid (cfg_valid),    // broadcast, channel filters on id
			.cfg_chan  (cfg_chan),
			.cfg_field (cfg_field),
			.cfg_data  (cfg_data),
			.update    (update),
			.smp       (smp_if[g]),
			.res       (res_if[g])
		);
	end

	opp_collect collect0 (
		.clk_in     (clk_in),
		.reset_in   (reset_in),
		.chan       (res_if),
		.dac_credit (dac_credit),
		.out_valid  (out_valid),
		.out_chan   (out_chan),
		.out_op     (out_op),
		.out_level  (out_level)
	);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the opp_top testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f src.f --top-module opp_tb -o opp_sim

./obj_dir/opp_sim | tee sim.log

if grep -q "^TESTBENCH PASSED$" sim.log; then
	echo "run_sim: simulation ok"
	exit 0
fi
echo "run_sim: simulation did not pass"
exit 1

// File: src.f
+incdir+hdl
hdl/opp_pkg.sv
hdl/opp_if.sv
hdl/opp_dispatch.sv
hdl/opp_channel.sv
hdl/opp_collect.sv
hdl/opp_top.sv
bench/opp_tb.sv
